/* logic/fft_pkg.sv */
//==================================================
// shared types and helpers for the fft stage engine
// holds the twiddle mode encoding and small width
// and fixed-point helper functions, imported by the
// rtl modules that need them
//==================================================
package fft_pkg;

  // twiddle classes, sorted once when a twiddle is written
  // general needs the multiplier, the rest are free rotations
  typedef enum logic [2:0] {
    tw_general = 3'd0,
    tw_pos_one = 3'd1,
    tw_neg_one = 3'd2,
    tw_pos_j   = 3'd3,
    tw_neg_j   = 3'd4
  } twiddle_mode_t;

  // width of a lane index, never below one bit
  function automatic int lane_index_w(input int lanes);
    return (lanes > 1) ? $clog2(lanes) : 1;
  endfunction

  // fixed-point one for a given number of fraction bits
  function automatic int fixed_one(input int frac_w);
    return 1 << frac_w;
  endfunction

  // width of a complex product sum before scale-down
  // two data_w products plus one bit for the add or subtract
  function automatic int product_w(input int data_w);
    return 2 * data_w + 1;
  endfunction

endpackage

/* logic/twiddle_if.sv */
//==================================================
// twiddle lookup between the config block and the
// butterfly, combinational within one cycle
// requester drives the lane, provider answers
//==================================================
interface twiddle_if #(
  parameter int data_w = 16,
  parameter int lanes  = 4
);
  import fft_pkg::*;

  // lane being processed by the butterfly
  logic [lane_index_w(lanes)-1:0] lane;

  // twiddle value and its precomputed class
  logic [data_w-1:0] w_re;
  logic [data_w-1:0] w_im;
  twiddle_mode_t     mode;

  modport requester (output lane, input w_re, w_im, mode);
  modport provider (input lane, output w_re, w_im, mode);

endinterface

/* logic/complex_multiplier.sv */
//==================================================
// fixed-point complex multiplier, one cycle latency
// p = a * b, truncated toward minus infinity by an
// arithmetic shift of frac_w, low data_w bits kept
// result only updates while en is high
//==================================================
module complex_multiplier #(
  parameter int data_w = 16,
  parameter int frac_w = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  input  logic [data_w-1:0] a_re,
  input  logic [data_w-1:0] a_im,
  input  logic [data_w-1:0] b_re,
  input  logic [data_w-1:0] b_im,
  output logic [data_w-1:0] p_re,
  output logic [data_w-1:0] p_im
);
  import fft_pkg::*;

  localparam int sum_w = product_w(data_w);

  // four partial products at double width
  logic signed [2*data_w-1:0] prod_rr;
  logic signed [2*data_w-1:0] prod_ii;
  logic signed [2*data_w-1:0] prod_ri;
  logic signed [2*data_w-1:0] prod_ir;
  logic signed [sum_w-1:0]    sum_re;
  logic signed [sum_w-1:0]    sum_im;

  assign prod_rr = $signed(a_re) * $signed(b_re);
  assign prod_ii = $signed(a_im) * $signed(b_im);
  assign prod_ri = $signed(a_re) * $signed(b_im);
  assign prod_ir = $signed(a_im) * $signed(b_re);

  // (ar + j ai)(br + j bi), extra bit keeps the sum exact
  assign sum_re = prod_rr - prod_ii;
  assign sum_im = prod_ri + prod_ir;

  always_ff @(posedge clk) begin
    if (reset) begin
      p_re <= '0;
      p_im <= '0;
    end else if (en) begin
      p_re <= data_w'(sum_re >>> frac_w);
      p_im <= data_w'(sum_im >>> frac_w);
    end
  end

endmodule

/* logic/twiddle_config.sv */
//==================================================
// per-lane twiddle register file
// each write is classified into a mode so that the
// butterfly can skip the multiplier on trivial lanes
// lookup through the twiddle interface is combinational
//==================================================
module twiddle_config #(
  parameter int data_w = 16,
  parameter int frac_w = 8,
  parameter int lanes  = 4
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    cfg_we,
  input  logic [fft_pkg::lane_index_w(lanes)-1:0] cfg_lane,
  input  logic [data_w-1:0]                       cfg_re,
  input  logic [data_w-1:0]                       cfg_im,
  twiddle_if.provider                             tw
);
  import fft_pkg::*;

  // plus and minus one in the data format
  localparam logic [data_w-1:0] pos_one = data_w'(fixed_one(frac_w));
  localparam logic [data_w-1:0] neg_one = data_w'(-fixed_one(frac_w));

  logic [data_w-1:0] w_re_mem [lanes];
  logic [data_w-1:0] w_im_mem [lanes];
  twiddle_mode_t     mode_mem [lanes];
  twiddle_mode_t     cfg_mode;

  // classify the incoming value
  // real axis gives +1 / -1, imaginary axis gives +j / -j
  always_comb begin
    cfg_mode = tw_general;
    if (cfg_im == '0) begin
      if (cfg_re == pos_one) cfg_mode = tw_pos_one;
      else if (cfg_re == neg_one) cfg_mode = tw_neg_one;
    end else if (cfg_re == '0) begin
      if (cfg_im == pos_one) cfg_mode = tw_pos_j;
      else if (cfg_im == neg_one) cfg_mode = tw_neg_j;
    end
  end

  // entries come out of reset as 1 + 0j
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < lanes; i++) begin
        w_re_mem[i] <= pos_one;
        w_im_mem[i] <= '0;
        mode_mem[i] <= tw_pos_one;
      end
    end else if (cfg_we) begin
      w_re_mem[cfg_lane] <= cfg_re;
      w_im_mem[cfg_lane] <= cfg_im;
      mode_mem[cfg_lane] <= cfg_mode;
    end
  end

  // lookup for the butterfly, same cycle
  assign tw.w_re = w_re_mem[tw.lane];
  assign tw.w_im = w_im_mem[tw.lane];
  assign tw.mode = mode_mem[tw.lane];

  // writes must land on an existing lane
  a_cfg_lane: assert property (@(posedge clk) disable iff (reset)
    cfg_we |-> (int'(cfg_lane) < lanes));

endmodule

/* logic/butterfly_iterative.sv */
//==================================================
// lane-serial radix-2 butterfly, c = a + wb, d = a - wb
// jobs move slot -> compute -> output register with
// credits on both sides, one multiplier shared by all
// lanes, trivial lanes 1 cycle, general lanes 2
//==================================================
module butterfly_iterative #(
  parameter int data_w      = 16,
  parameter int frac_w      = 8,
  parameter int lanes       = 4,
  parameter int out_credits = 2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [lanes*data_w-1:0] in_a_re,
  input  logic [lanes*data_w-1:0] in_a_im,
  input  logic [lanes*data_w-1:0] in_b_re,
  input  logic [lanes*data_w-1:0] in_b_im,
  output logic                    in_credit,
  input  logic                    out_credit,
  output logic                    out_valid,
  output logic [lanes*data_w-1:0] out_c_re,
  output logic [lanes*data_w-1:0] out_c_im,
  output logic [lanes*data_w-1:0] out_d_re,
  output logic [lanes*data_w-1:0] out_d_im,
  twiddle_if.requester            tw
);
  import fft_pkg::*;

  localparam int lane_w = lane_index_w(lanes);
  localparam int cred_w = $clog2(out_credits + 1);

  // compute states
  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_issue  = 2'd1;
  localparam logic [1:0] st_finish = 2'd2;
  localparam logic [1:0] st_hold   = 2'd3;

  logic                    slot_full;
  logic [lanes*data_w-1:0] slot_a_re, slot_a_im, slot_b_re, slot_b_im;
  // working set, a/b are overwritten in place by c/d lane by lane
  logic [lanes*data_w-1:0] cur_a_re, cur_a_im, cur_b_re, cur_b_im;
  logic [1:0]              state;
  logic [lane_w-1:0]       lane_cnt;
  logic                    load, last_lane, mult_en, write_lane;
  logic signed [data_w-1:0] a_re, a_im, b_re, b_im;
  logic signed [data_w-1:0] m_re, m_im, p_re, p_im;
  logic                    out_full, send, out_free, move_out;
  logic [cred_w-1:0]       credit_cnt;

  // ================================================
  // input slot
  // ================================================
  // slot empties into compute when the fsm is idle, which frees the credit
  assign load      = slot_full && (state == st_idle);
  assign in_credit = load;

  always_ff @(posedge clk) begin
    if (reset) slot_full <= 1'b0;
    else if (in_valid) slot_full <= 1'b1;
    else if (load) slot_full <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      slot_a_re <= in_a_re;
      slot_a_im <= in_a_im;
      slot_b_re <= in_b_re;
      slot_b_im <= in_b_im;
    end
  end

  // ================================================
  // lane-serial compute
  // ================================================
  assign tw.lane    = lane_cnt;
  assign last_lane  = (lane_cnt == lane_w'(lanes - 1));
  assign mult_en    = (state == st_issue) && (tw.mode == tw_general);
  assign write_lane = ((state == st_issue) && (tw.mode != tw_general)) ||
                      (state == st_finish);

  assign a_re = cur_a_re[lane_cnt*data_w +: data_w];
  assign a_im = cur_a_im[lane_cnt*data_w +: data_w];
  assign b_re = cur_b_re[lane_cnt*data_w +: data_w];
  assign b_im = cur_b_im[lane_cnt*data_w +: data_w];

  // product is ready the cycle after issue
  complex_multiplier #(.data_w(data_w), .frac_w(frac_w)) u_mult (
    .clk  (clk),
    .reset(reset),
    .en   (mult_en),
    .a_re (b_re),
    .a_im (b_im),
    .b_re (tw.w_re),
    .b_im (tw.w_im),
    .p_re (m_re),
    .p_im (m_im)
  );

  // w*b, trivial rotations bypass the multiplier and stay exact
  always_comb begin
    p_re = b_re;
    p_im = b_im;
    if (state == st_finish) begin
      p_re = m_re;
      p_im = m_im;
    end else begin
      case (tw.mode)
        tw_neg_one: begin p_re = -b_re; p_im = -b_im; end
        tw_pos_j:   begin p_re = -b_im; p_im = b_re;  end
        tw_neg_j:   begin p_re = b_im;  p_im = -b_re; end
        default:    begin p_re = b_re;  p_im = b_im;  end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      lane_cnt <= '0;
    end else begin
      case (state)
        st_idle: if (load) begin
          state    <= st_issue;
          lane_cnt <= '0;
        end
        st_issue: begin
          if (tw.mode == tw_general) state <= st_finish;
          else if (last_lane) state <= st_hold;
          else lane_cnt <= lane_cnt + 1'b1;
        end
        st_finish: begin
          if (last_lane) begin
            state <= st_hold;
          end else begin
            state    <= st_issue;
            lane_cnt <= lane_cnt + 1'b1;
          end
        end
        default: if (out_free) state <= st_idle;
      endcase
    end
  end

  // c = a + p lands in the a slots, d = a - p in the b slots, both wrap
  always_ff @(posedge clk) begin
    if (load) begin
      cur_a_re <= slot_a_re;
      cur_a_im <= slot_a_im;
      cur_b_re <= slot_b_re;
      cur_b_im <= slot_b_im;
    end else if (write_lane) begin
      cur_a_re[lane_cnt*data_w +: data_w] <= a_re + p_re;
      cur_a_im[lane_cnt*data_w +: data_w] <= a_im + p_im;
      cur_b_re[lane_cnt*data_w +: data_w] <= a_re - p_re;
      cur_b_im[lane_cnt*data_w +: data_w] <= a_im - p_im;
    end
  end

  // ================================================
  // output register and downstream credits
  // ================================================
  assign send      = out_full && (credit_cnt != '0);
  assign out_valid = send;
  assign out_free  = !out_full || send;
  assign move_out  = (state == st_hold) && out_free;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_full   <= 1'b0;
      credit_cnt <= cred_w'(out_credits);
    end else begin
      if (move_out) out_full <= 1'b1;
      else if (send) out_full <= 1'b0;
      credit_cnt <= credit_cnt + cred_w'(out_credit) - cred_w'(send);
    end
  end

  always_ff @(posedge clk) begin
    if (move_out) begin
      out_c_re <= cur_a_re;
      out_c_im <= cur_a_im;
      out_d_re <= cur_b_re;
      out_d_im <= cur_b_im;
    end
  end

  // upstream holds a single credit, so a new job never meets a full slot
  a_slot_free: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> !slot_full);

  // downstream never returns more credits than it was granted
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    (out_credit && !send) |-> (credit_cnt < cred_w'(out_credits)));

endmodule

/* logic/butterfly_engine.sv */
//==================================================
// radix-2 fft stage engine, top level
// twiddle config block beside a lane-serial butterfly
// credit flow control on input and output channels
//==================================================
module butterfly_engine #(
  parameter int data_w      = 16,
  parameter int frac_w      = 8,
  parameter int lanes       = 4,
  parameter int out_credits = 2
) (
  input  logic                                    clk,
  input  logic                                    reset,
  // input channel
  input  logic                                    in_valid,
  input  logic [lanes*data_w-1:0]                 in_a_re,
  input  logic [lanes*data_w-1:0]                 in_a_im,
  input  logic [lanes*data_w-1:0]                 in_b_re,
  input  logic [lanes*data_w-1:0]                 in_b_im,
  output logic                                    in_credit,
  // output channel
  output logic                                    out_valid,
  output logic [lanes*data_w-1:0]                 out_c_re,
  output logic [lanes*data_w-1:0]                 out_c_im,
  output logic [lanes*data_w-1:0]                 out_d_re,
  output logic [lanes*data_w-1:0]                 out_d_im,
  input  logic                                    out_credit,
  // twiddle configuration, only while drained
  input  logic                                    cfg_we,
  input  logic [fft_pkg::lane_index_w(lanes)-1:0] cfg_lane,
  input  logic [data_w-1:0]                       cfg_re,
  input  logic [data_w-1:0]                       cfg_im
);

  // per-lane twiddle lookup
  twiddle_if #(.data_w(data_w), .lanes(lanes)) tw_bus ();

  twiddle_config #(.data_w(data_w), .frac_w(frac_w), .lanes(lanes)) u_twiddle_config (
    .clk     (clk),
    .reset   (reset),
    .cfg_we  (cfg_we),
    .cfg_lane(cfg_lane),
    .cfg_re  (cfg_re),
    .cfg_im  (cfg_im),
    .tw      (tw_bus.provider)
  );

  butterfly_iterative #(
    .data_w     (data_w),
    .frac_w     (frac_w),
    .lanes      (lanes),
    .out_credits(out_credits)
  ) u_butterfly (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_a_re   (in_a_re),
    .in_a_im   (in_a_im),
    .in_b_re   (in_b_re),
    .in_b_im   (in_b_im),
    .in_credit (in_credit),
    .out_credit(out_credit),
    .out_valid (out_valid),
    .out_c_re  (out_c_re),
    .out_c_im  (out_c_im),
    .out_d_re  (out_d_re),
    .out_d_im  (out_d_im),
    .tw        (tw_bus.requester)
  );

endmodule

/* verification/butterfly_engine_tb.sv */
//==================================================
// testbench for the fft butterfly engine
// random jobs and twiddles from a fixed seed, a
// model of c = a + wb and d = a - wb, and both
// credit loops emulated around the DUT
//==================================================
module butterfly_engine_tb;

  localparam int data_w      = 16;
  localparam int frac_w      = 8;
  localparam int lanes       = 4;
  localparam int out_credits = 2;
  localparam int vec_w       = lanes * data_w;
  localparam int lane_w      = fft_pkg::lane_index_w(lanes);
  localparam int total_jobs  = 40;
  // worst lane time per job plus slack, and margin for config and stall phases
  localparam int cycle_limit = total_jobs * (2 * lanes + 8) + 400;

  logic clk, reset;
  logic in_valid, in_credit, out_valid, out_credit;
  logic [vec_w-1:0] in_a_re, in_a_im, in_b_re, in_b_im;
  logic [vec_w-1:0] out_c_re, out_c_im, out_d_re, out_d_im;
  logic cfg_we;
  logic [lane_w-1:0] cfg_lane;
  logic [data_w-1:0] cfg_re, cfg_im;

  // model state
  logic [data_w-1:0]  tw_re [lanes];
  logic [data_w-1:0]  tw_im [lanes];
  logic [4*vec_w-1:0] expected_q [$];
  bit running, stalled, up_credit, take_credit;
  int send_target, jobs_sent, jobs_recv, pending_return, results_out, credits_back;
  int data_errors, protocol_errors, timeout_errors, cycle_count;

  butterfly_engine #(
    .data_w(data_w), .frac_w(frac_w), .lanes(lanes), .out_credits(out_credits)
  ) DUT (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_a_re(in_a_re), .in_a_im(in_a_im),
    .in_b_re(in_b_re), .in_b_im(in_b_im), .in_credit(in_credit),
    .out_valid(out_valid), .out_c_re(out_c_re), .out_c_im(out_c_im),
    .out_d_re(out_d_re), .out_d_im(out_d_im), .out_credit(out_credit),
    .cfg_we(cfg_we), .cfg_lane(cfg_lane), .cfg_re(cfg_re), .cfg_im(cfg_im)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ================================================
  // model and helpers
  // ================================================
  // random a and b per lane with expected c and d pushed in send order
  task automatic build_job();
    logic [vec_w-1:0] c_re, c_im, d_re, d_im;
    longint ar, ai, br, bi, wr, wi, p_re, p_im;
    for (int l = 0; l < lanes; l++) begin
      in_a_re[l*data_w +: data_w] = data_w'($urandom);
      in_a_im[l*data_w +: data_w] = data_w'($urandom);
      in_b_re[l*data_w +: data_w] = data_w'($urandom);
      in_b_im[l*data_w +: data_w] = data_w'($urandom);
      ar = $signed(in_a_re[l*data_w +: data_w]);
      ai = $signed(in_a_im[l*data_w +: data_w]);
      br = $signed(in_b_re[l*data_w +: data_w]);
      bi = $signed(in_b_im[l*data_w +: data_w]);
      wr = $signed(tw_re[l]);
      wi = $signed(tw_im[l]);
      // w*b at full precision, then floor by 2^frac_w
      // for w = +-1 or +-j this is an exact rotation of b
      p_re = (br * wr - bi * wi) >>> frac_w;
      p_im = (br * wi + bi * wr) >>> frac_w;
      // sums wrap, so only the low data_w bits matter
      c_re[l*data_w +: data_w] = data_w'(ar + p_re);
      c_im[l*data_w +: data_w] = data_w'(ai + p_im);
      d_re[l*data_w +: data_w] = data_w'(ar - p_re);
      d_im[l*data_w +: data_w] = data_w'(ai - p_im);
    end
    expected_q.push_back({c_re, c_im, d_re, d_im});
  endtask

  task automatic compare_word(input string what, input int lane,
                              input logic [data_w-1:0] got, input logic [data_w-1:0] exp);
    assert (got === exp) else begin
      data_errors++;
      $display("** Error at %0t: job %0d lane %0d %s is %h, expected %h",
               $time, jobs_recv, lane, what, got, exp);
    end
  endtask

  task automatic check_result();
    logic [4*vec_w-1:0] exp;
    assert (expected_q.size() != 0) else begin
      protocol_errors++;
      $display("out_valid came at %0t with no job outstanding", $time);
    end
    if (expected_q.size() != 0) begin
      exp = expected_q.pop_front();
      for (int l = 0; l < lanes; l++) begin
        compare_word("c_re", l, out_c_re[l*data_w +: data_w], exp[3*vec_w + l*data_w +: data_w]);
        compare_word("c_im", l, out_c_im[l*data_w +: data_w], exp[2*vec_w + l*data_w +: data_w]);
        compare_word("d_re", l, out_d_re[l*data_w +: data_w], exp[vec_w + l*data_w +: data_w]);
        compare_word("d_im", l, out_d_im[l*data_w +: data_w], exp[l*data_w +: data_w]);
      end
    end
  endtask

  // kind 0 is general in [-1, 1] and kinds 1 to 4 are +1, -1, +j and -j
  // the result packs re above im
  function automatic logic [2*data_w-1:0] pick_twiddle(input int kind);
    int one;
    one = 1 << frac_w;
    case (kind)
      1: return {data_w'(one), data_w'(0)};
      2: return {data_w'(-one), data_w'(0)};
      3: return {data_w'(0), data_w'(one)};
      4: return {data_w'(0), data_w'(-one)};
      default: return {data_w'(int'($urandom_range(2 * one)) - one),
                       data_w'(int'($urandom_range(2 * one)) - one)};
    endcase
  endfunction

  task automatic write_twiddle(input int lane, input logic [2*data_w-1:0] w);
    @(negedge clk);
    cfg_we   = 1'b1;
    cfg_lane = lane_w'(lane);
    cfg_re   = w[2*data_w-1:data_w];
    cfg_im   = w[data_w-1:0];
    tw_re[lane] = w[2*data_w-1:data_w];
    tw_im[lane] = w[data_w-1:0];
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // all general, or trivial kinds rotated across the lanes by offset
  task automatic load_twiddles(input int offset, input bit all_general);
    for (int l = 0; l < lanes; l++) begin
      write_twiddle(l, pick_twiddle(all_general ? 0 : (l + offset) % 5));
    end
    @(posedge clk);
  endtask

  task automatic run_burst(input int n);
    send_target += n;
    while (jobs_sent < send_target) @(posedge clk);
    // drained means every result out, every credit back on both sides
    while (!(jobs_recv == jobs_sent && pending_return == 0 && up_credit)) @(posedge clk);
  endtask

  task automatic finish_run();
    $display("errors: %0d total, %0d data, %0d protocol, %0d timeout",
             data_errors + protocol_errors + timeout_errors,
             data_errors, protocol_errors, timeout_errors);
    if (data_errors + protocol_errors + timeout_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // ================================================
  // upstream and downstream emulation, falling edge
  // ================================================
  always @(negedge clk) begin
    if (running) begin
      take_credit = 1'b0;
      // nothing may come out before the first job
      if (jobs_sent == 0) begin
        assert (!out_valid && !in_credit) else begin
          protocol_errors++;
          $display("output activity at %0t before any job was sent", $time);
        end
      end
      // in_credit only for a job in the slot, never with three in flight
      if (in_credit) begin
        assert (!up_credit && (jobs_sent - jobs_recv) <= 2) else begin
          protocol_errors++;
          $display("in_credit at %0t with no job in the slot or three in flight", $time);
        end
        take_credit = 1'b1;
      end
      if (out_valid) begin
        check_result();
        jobs_recv++;
        pending_return++;
        results_out++;
        assert (results_out <= out_credits + credits_back) else begin
          protocol_errors++;
          $display("result at %0t sent without a downstream credit", $time);
        end
      end
      assert ((jobs_sent - jobs_recv) <= 3) else begin
        protocol_errors++;
        $display("more than three jobs in flight at %0t", $time);
      end
      // new job only with the upstream credit in hand
      in_valid = 1'b0;
      if (jobs_sent < send_target && up_credit && $urandom_range(3) != 0) begin
        build_job();
        in_valid  = 1'b1;
        up_credit = 1'b0;
        jobs_sent++;
      end
      if (take_credit) up_credit = 1'b1;
      // downstream hands credits back at random, none while stalled
      out_credit = 1'b0;
      if (!stalled && pending_return > 0 && $urandom_range(1) == 1) begin
        out_credit = 1'b1;
        pending_return--;
        credits_back++;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    timeout_errors++;
    $display("timeout, the run did not finish within %0d cycles", cycle_limit);
    finish_run();
  end

  // ================================================
  // test sequence
  // ================================================
  initial begin
    void'($urandom(32'h379b));
    reset       = 1'b1;
    running     = 1'b0;
    stalled     = 1'b0;
    up_credit   = 1'b1;
    send_target = 0;
    in_valid    = 1'b0;
    in_a_re     = '0;
    in_a_im     = '0;
    in_b_re     = '0;
    in_b_im     = '0;
    out_credit  = 1'b0;
    cfg_we      = 1'b0;
    cfg_lane    = '0;
    cfg_re      = '0;
    cfg_im      = '0;
    // model table matches the reset value 1 + 0j
    for (int l = 0; l < lanes; l++) begin
      tw_re[l] = data_w'(1 << frac_w);
      tw_im[l] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    running = 1'b1;
    // quiet stretch after reset
    repeat (5) @(posedge clk);
    load_twiddles(0, 1'b1);
    run_burst(12);
    // trivial kinds mixed with general lanes in two layouts
    load_twiddles(0, 1'b0);
    run_burst(6);
    load_twiddles(3, 1'b0);
    run_burst(6);
    // with the downstream stalled the engine fills all three stages and stops
    stalled = 1'b1;
    send_target += 8;
    while (jobs_sent - jobs_recv < 3) @(posedge clk);
    repeat (20) @(posedge clk);
    assert (jobs_sent - jobs_recv == 3) else begin
      protocol_errors++;
      $display("engine did not hold three jobs during the output stall");
    end
    stalled = 1'b0;
    run_burst(0);
    // fresh twiddles take effect for the next burst
    load_twiddles(0, 1'b1);
    run_burst(8);
    assert (jobs_recv == total_jobs && expected_q.size() == 0) else begin
      protocol_errors++;
      $display("only %0d of %0d results came back", jobs_recv, total_jobs);
    end
    finish_run();
  end

endmodule

/* butterfly_engine.f */
logic/fft_pkg.sv
logic/twiddle_if.sv
logic/complex_multiplier.sv
logic/twiddle_config.sv
logic/butterfly_iterative.sv
logic/butterfly_engine.sv
verification/butterfly_engine_tb.sv

/* Makefile */
# Verilator build and run for the fft butterfly engine
VERILATOR ?= verilator
TOP       ?= butterfly_engine_tb
RTL_TOP   ?= butterfly_engine
FILELIST  ?= butterfly_engine.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
